// File: src/keygen_pkg.sv
`default_nettype none

package keygen_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////

	localparam int RNG_W = 64;      // one generator word
	localparam int IDX_W = 14;      // one sparse index
	localparam int IDX_HI_LSB = 16; // high index starts here

	//////////////////////////////
	// payloads
	//////////////////////////////

	typedef logic [RNG_W-1:0] rng_word_t; // dense payload
	typedef logic [IDX_W-1:0] sparse_idx_t;

	// 28-bit sparse payload
	typedef struct packed {
		sparse_idx_t hi;
		sparse_idx_t lo;
	} idx_pair_t;

	//////////////////////////////
	// encodings
	//////////////////////////////

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DENSE,   // filling g
		ST_SPARSE,  // filling h
		ST_DONE
	} keygen_state_t;

	typedef logic [1:0] rng_req_t;

	localparam rng_req_t RNG_REQ_NONE   = 2'b00;
	localparam rng_req_t RNG_REQ_DENSE  = 2'b01;
	localparam rng_req_t RNG_REQ_SPARSE = 2'b10; // 11 is never issued

endpackage

`default_nettype wire

// File: src/poly_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface poly_mem_if #(
	parameter type payload_t = logic,
	parameter int DEPTH = 2
);

	localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic wr_en;
	logic [ADDR_W-1:0] wr_addr;
	payload_t wr_data;
	logic [ADDR_W-1:0] rd_addr;
	payload_t rd_data; // one cycle after rd_addr

	modport loader (
		output wr_en,
		output wr_addr,
		output wr_data
	);

	modport ram (
		input wr_en,
		input wr_addr,
		input wr_data,
		input rd_addr,
		output rd_data
	);

	modport reader (
		output rd_addr,
		input rd_data
	);

endinterface

`default_nettype wire

// File: src/keygen_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module keygen_fsm import keygen_pkg::*; (
	input logic clk,
	input logic rst_b,
	input logic start,
	input logic g_full,
	input logic h_full,
	output keygen_state_t state,
	output rng_req_t rng_start,
	output logic run_clear,
	output logic done
);

	keygen_state_t next_state;
	logic start_run;

	assign start_run = start && (state == ST_IDLE || state == ST_DONE);

	always_comb begin
		next_state = state;
		case (state)
			ST_IDLE: if (start_run) next_state = ST_DENSE;
			// full flags still hold the last run while run_clear is high
			ST_DENSE: if (g_full && !run_clear) next_state = ST_SPARSE;
			ST_SPARSE: if (h_full) next_state = ST_DONE;
			ST_DONE: if (start_run) next_state = ST_DENSE; // new run
			default: next_state = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_b) begin
			state <= ST_IDLE;
			run_clear <= 1'b0;
		end else begin
			state <= next_state;
			run_clear <= start_run; // first cycle of ST_DENSE
		end
	end

	//////////////////////////////
	// moore outputs
	//////////////////////////////

	always_comb begin
		case (state)
			ST_DENSE: rng_start = RNG_REQ_DENSE;
			ST_SPARSE: rng_start = RNG_REQ_SPARSE;
			default: rng_start = RNG_REQ_NONE;
		endcase
	end

	assign done = (state == ST_DONE);

endmodule

`default_nettype wire

// File: src/fill_counter.sv
`timescale 1ns/1ps
`default_nettype none

module fill_counter #(
	parameter int COUNT = 4
) (
	input logic clk,
	input logic rst_b,
	input logic clear,
	input logic step,
	output logic [((COUNT > 1) ? $clog2(COUNT) : 1)-1:0] count,
	output logic full
);

	localparam int ADDR_W = (COUNT > 1) ? $clog2(COUNT) : 1;

	// count holds the next free address and full marks the COUNT-th step
	always_ff @(posedge clk) begin
		if (!rst_b) begin
			count <= '0;
			full <= 1'b0;
		end else if (clear) begin
			count <= '0; // new run
			full <= 1'b0;
		end else if (step && !full) begin
			if (count == ADDR_W'(COUNT - 1))
				full <= 1'b1; // last address taken
			else
				count <= count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: src/rng_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module rng_sampler import keygen_pkg::*; #(
	parameter int R = 11027
) (
	input logic clk,
	input logic rst_b,
	input keygen_state_t state,
	input logic rng_valid,
	input rng_word_t rng_in,
	output logic dense_push,
	output rng_word_t dense_data,
	output logic sparse_push,
	output idx_pair_t sparse_data
);

	sparse_idx_t idx_lo;
	sparse_idx_t idx_hi;
	logic idx_ok;

	//////////////////////////////
	// rejection test
	//////////////////////////////

	assign idx_lo = rng_in[IDX_W-1:0];                    // bits 13..0
	assign idx_hi = rng_in[IDX_HI_LSB +: IDX_W];          // bits 29..16
	assign idx_ok = (idx_lo < R) && (idx_hi < R);         // whole word or nothing

	// push strobes registered and qualified by phase
	always_ff @(posedge clk) begin
		if (!rst_b) begin
			dense_push <= 1'b0;
			sparse_push <= 1'b0;
		end else begin
			dense_push <= (state == ST_DENSE) && rng_valid;
			sparse_push <= (state == ST_SPARSE) && rng_valid && idx_ok;
		end
	end

	always_ff @(posedge clk) begin
		dense_data <= rng_in;
		sparse_data.hi <= idx_hi;
		sparse_data.lo <= idx_lo;
	end

endmodule

`default_nettype wire

// File: src/sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sample_fifo #(
	parameter type payload_t = logic,
	parameter int DEPTH = 8
) (
	input logic clk,
	input logic rst_b,
	input logic clear,
	input logic push,
	input payload_t din,
	input logic pop,
	output payload_t dout,
	output logic empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	payload_t buffer [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] level; // occupancy
	logic do_push;
	logic do_pop;

	assign do_push = push && (level != DEPTH); // drop on overflow
	assign do_pop = pop && (level != 0);

	always_ff @(posedge clk) begin
		if (!rst_b || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				level <= level + 1'b1;
			else if (do_pop && !do_push)
				level <= level - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			buffer[wr_ptr] <= din;
	end

	assign dout = buffer[rd_ptr]; // show-ahead
	assign empty = (level == 0);

endmodule

`default_nettype wire

// File: src/poly_ram.sv
`timescale 1ns/1ps
`default_nettype none

module poly_ram #(
	parameter type payload_t = logic,
	parameter int DEPTH = 2
) (
	poly_mem_if.ram mem,
	input logic clk
);

	payload_t storage [DEPTH]; // polynomial words

	//////////////////////////////
	// write port
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (mem.wr_en)
			storage[mem.wr_addr] <= mem.wr_data;
	end

	//////////////////////////////
	// read port
	//////////////////////////////

	always_ff @(posedge clk) begin
		mem.rd_data <= storage[mem.rd_addr]; // 1 cycle latency
	end

endmodule

`default_nettype wire

// File: src/poly_loader.sv
`timescale 1ns/1ps
`default_nettype none

module poly_loader #(
	parameter type payload_t = logic,
	parameter int COUNT = 4
) (
	input logic clk,
	input logic rst_b,
	input logic clear,
	input logic fifo_empty,
	input payload_t fifo_data,
	output logic fifo_pop,
	poly_mem_if.loader mem,
	output logic full
);

	localparam int ADDR_W = (COUNT > 1) ? $clog2(COUNT) : 1;

	logic [ADDR_W-1:0] count;

	// counter steps on pop so an in-flight write never overshoots
	assign fifo_pop = !fifo_empty && !full && !clear;

	fill_counter #(
		.COUNT(COUNT)
	) fill_counter_i (
		.clk(clk),
		.rst_b(rst_b),
		.clear(clear),
		.step(fifo_pop),
		.count(count),
		.full(full)
	);

	//////////////////////////////
	// write stage
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_b || clear)
			mem.wr_en <= 1'b0;
		else
			mem.wr_en <= fifo_pop;
	end

	always_ff @(posedge clk) begin
		mem.wr_addr <= count;     // address at pop time
		mem.wr_data <= fifo_data;
	end

endmodule

`default_nettype wire

// File: src/keygen_top.sv
`timescale 1ns/1ps
`default_nettype none

module keygen_top import keygen_pkg::*; #(
	parameter int R = 11027,
	parameter int G_WORDS = 173,
	parameter int H_PAIRS = 67,
	parameter int FIFO_DEPTH = 8
) (
	input logic clk,
	input logic rst_b,
	input logic start,
	input logic rng_valid,
	input rng_word_t rng_in,
	output rng_req_t rng_start,
	output logic done,
	input logic [((G_WORDS > 1) ? $clog2(G_WORDS) : 1)-1:0] rd_addr,
	output rng_word_t g_rd_data,
	output idx_pair_t h_rd_data
);

	localparam int H_AW = (H_PAIRS > 1) ? $clog2(H_PAIRS) : 1;

	keygen_state_t state;
	logic run_clear;
	logic g_full, h_full;
	logic dense_push, sparse_push;
	rng_word_t dense_data;
	idx_pair_t sparse_data;
	logic g_fifo_empty, h_fifo_empty;
	logic g_fifo_pop, h_fifo_pop;
	rng_word_t g_fifo_dout;
	idx_pair_t h_fifo_dout;

	poly_mem_if #(.payload_t(rng_word_t), .DEPTH(G_WORDS)) g_mem ();
	poly_mem_if #(.payload_t(idx_pair_t), .DEPTH(H_PAIRS)) h_mem ();

	keygen_fsm keygen_fsm_i (
		.clk(clk),
		.rst_b(rst_b),
		.start(start),
		.g_full(g_full),
		.h_full(h_full),
		.state(state),
		.rng_start(rng_start),
		.run_clear(run_clear),
		.done(done)
	);

	rng_sampler #(.R(R)) rng_sampler_i (
		.clk(clk),
		.rst_b(rst_b),
		.state(state),
		.rng_valid(rng_valid),
		.rng_in(rng_in),
		.dense_push(dense_push),
		.dense_data(dense_data),
		.sparse_push(sparse_push),
		.sparse_data(sparse_data)
	);

	//////////////////////////////
	// dense path into g
	//////////////////////////////

	sample_fifo #(.payload_t(rng_word_t), .DEPTH(FIFO_DEPTH)) g_fifo_i (
		.clk(clk),
		.rst_b(rst_b),
		.clear(run_clear),
		.push(dense_push),
		.din(dense_data),
		.pop(g_fifo_pop),
		.dout(g_fifo_dout),
		.empty(g_fifo_empty)
	);

	poly_loader #(.payload_t(rng_word_t), .COUNT(G_WORDS)) g_loader_i (
		.clk(clk),
		.rst_b(rst_b),
		.clear(run_clear),
		.fifo_empty(g_fifo_empty),
		.fifo_data(g_fifo_dout),
		.fifo_pop(g_fifo_pop),
		.mem(g_mem.loader),
		.full(g_full)
	);

	poly_ram #(.payload_t(rng_word_t), .DEPTH(G_WORDS)) g_ram_i (
		.mem(g_mem.ram),
		.clk(clk)
	);

	//////////////////////////////
	// sparse path into h
	//////////////////////////////

	sample_fifo #(.payload_t(idx_pair_t), .DEPTH(FIFO_DEPTH)) h_fifo_i (
		.clk(clk),
		.rst_b(rst_b),
		.clear(run_clear),
		.push(sparse_push),
		.din(sparse_data),
		.pop(h_fifo_pop),
		.dout(h_fifo_dout),
		.empty(h_fifo_empty)
	);

	poly_loader #(.payload_t(idx_pair_t), .COUNT(H_PAIRS)) h_loader_i (
		.clk(clk),
		.rst_b(rst_b),
		.clear(run_clear),
		.fifo_empty(h_fifo_empty),
		.fifo_data(h_fifo_dout),
		.fifo_pop(h_fifo_pop),
		.mem(h_mem.loader),
		.full(h_full)
	);

	poly_ram #(.payload_t(idx_pair_t), .DEPTH(H_PAIRS)) h_ram_i (
		.mem(h_mem.ram),
		.clk(clk)
	);

	// h takes the low bits of the shared read address
	assign g_mem.rd_addr = rd_addr;
	assign h_mem.rd_addr = rd_addr[H_AW-1:0];
	assign g_rd_data = g_mem.rd_data;
	assign h_rd_data = h_mem.rd_data;

endmodule

`default_nettype wire

// File: dv/keygen_checker.sv
`timescale 1ns/1ps
`default_nettype none

module keygen_checker import keygen_pkg::*; #(
	parameter int R = 11027
) (
	input logic clk,
	input logic rst_b,
	input logic start,
	input rng_req_t rng_start,
	input logic done,
	input logic run_clear,
	input logic h_wr_en,
	input idx_pair_t h_wr_data
);

	req_code_valid: assert property (@(posedge clk) disable iff (!rst_b)
		rng_start != 2'b11) // unused code
		else $error("rng_start carries the unused code 11");

	done_no_request: assert property (@(posedge clk) disable iff (!rst_b)
		done |-> rng_start == RNG_REQ_NONE)
		else $error("rng_start is nonzero while done is high");

	h_write_in_range: assert property (@(posedge clk) disable iff (!rst_b)
		h_wr_en |-> (h_wr_data.hi < R && h_wr_data.lo < R))
		else $error("h memory written with an index not below R");

	clear_after_start: assert property (@(posedge clk) disable iff (!rst_b)
		run_clear |-> $past(start)) // one pulse per accepted start
		else $error("run_clear without start in the previous cycle");

endmodule

bind keygen_top keygen_checker #(
	.R(R)
) keygen_checker_i (
	.clk(clk),
	.rst_b(rst_b),
	.start(start),
	.rng_start(rng_start),
	.done(done),
	.run_clear(run_clear),
	.h_wr_en(h_mem.wr_en),
	.h_wr_data(h_mem.wr_data)
);

`default_nettype wire

// File: dv/keygen_tb.sv
`timescale 1ns/1ps
`default_nettype none

module keygen_tb import keygen_pkg::*; ();

	localparam int R = 11027;
	localparam int G_WORDS = 6;
	localparam int H_PAIRS = 4;
	localparam int RD_AW = (G_WORDS > 1) ? $clog2(G_WORDS) : 1;
	localparam int N_ROWS = 3;
	localparam int CLK_PERIOD = 20;
	localparam logic [63:0] LFSR_TAPS = 64'hD800_0000_0000_0000; // x^64+x^63+x^61+x^60+1

	//////////////////////////////
	// stimulus table
	//////////////////////////////

	// each row holds the gap flag, forced sparse words (hi, lo) and repeat count of a run group
	bit row_gaps [N_ROWS] = '{1'b0, 1'b1, 1'b1};
	int row_forced [N_ROWS] = '{2, 4, 3};
	int row_hi [N_ROWS][4] = '{'{5, R, 0, 0}, '{3, R + 1, 16383, R - 1}, '{0, R, R - 1, 0}};
	int row_lo [N_ROWS][4] = '{'{R - 1, 7, 0, 0}, '{R, 9, R + 200, R - 1}, '{R + 1, R, 0, 0}};
	int row_runs [N_ROWS] = '{1, 2, 1};

	logic clk = 1'b0;
	logic rst_b;
	logic start;
	logic rng_valid;
	rng_word_t rng_in;
	rng_req_t rng_start;
	logic done;
	logic [RD_AW-1:0] rd_addr;
	rng_word_t g_rd_data;
	idx_pair_t h_rd_data;

	logic [63:0] lfsr = 64'd29;
	rng_word_t dense_q [$]; // accepted dense words in order
	idx_pair_t sparse_q [$]; // sparse words that pass the index test
	rng_req_t last_req = RNG_REQ_NONE;
	int cur_row = 0;
	int force_pos = 0;
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	keygen_top #(
		.R(R),
		.G_WORDS(G_WORDS),
		.H_PAIRS(H_PAIRS)
	) keygen_top_i (
		.clk(clk),
		.rst_b(rst_b),
		.start(start),
		.rng_valid(rng_valid),
		.rng_in(rng_in),
		.rng_start(rng_start),
		.done(done),
		.rd_addr(rd_addr),
		.g_rd_data(g_rd_data),
		.h_rd_data(h_rd_data)
	);

	function automatic logic [63:0] lfsr_next(input logic [63:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [63:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[62:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// bits outside both index fields are set to show they are ignored
	function automatic rng_word_t forced_word(input int hi, input int lo);
		return {32'h5a5a_c3c3, 2'b11, 14'(hi), 2'b11, 14'(lo)};
	endfunction

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic check_memories();
		assert (dense_q.size() >= G_WORDS && sparse_q.size() >= H_PAIRS) else begin
			$display("done came before enough words were accepted by the model");
			errors++;
			return;
		end
		for (int a = 0; a < G_WORDS; a++) begin
			rd_addr = RD_AW'(a);
			@(negedge clk); // one cycle read latency
			assert (g_rd_data === dense_q[a]) else begin
				$display("[ERROR] %0d ns: g addr %0d read %h, expected %h",
					$time, a, g_rd_data, dense_q[a]);
				errors++;
			end
			if (a < H_PAIRS) begin
				assert (h_rd_data === sparse_q[a]) else begin
					$display("[ERROR] %0d ns: h addr %0d read %h, expected %h",
						$time, a, h_rd_data, sparse_q[a]);
					errors++;
				end
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////
	// generator model
	//////////////////////////////

	always @(negedge clk) begin
		logic [63:0] bits;
		rng_word_t word;
		idx_pair_t pair;
		logic valid;
		if (rng_start == RNG_REQ_NONE) begin
			rng_valid = 1'b0;
		end else begin
			valid = 1'b1;
			if (rng_start == RNG_REQ_SPARSE && force_pos < row_forced[cur_row]) begin
				word = forced_word(row_hi[cur_row][force_pos], row_lo[cur_row][force_pos]);
				force_pos++;
			end else begin
				if (row_gaps[cur_row]) begin
					take_bits(1, bits); // gap decision
					valid = bits[0];
				end
				take_bits(64, bits);
				word = bits;
			end
			rng_valid = valid;
			rng_in = word;
			pair.hi = word[IDX_HI_LSB +: IDX_W];
			pair.lo = word[IDX_W-1:0];
			if (valid && rng_start == RNG_REQ_DENSE)
				dense_q.push_back(word);
			else if (valid && pair.hi < R && pair.lo < R)
				sparse_q.push_back(pair); // both indices below R
		end
		// request sequence is 00 -> 01 -> 10 -> 00 with done
		assert (!(last_req == RNG_REQ_SPARSE && rng_start == RNG_REQ_DENSE)
			&& !(last_req == RNG_REQ_DENSE && rng_start == RNG_REQ_NONE)
			&& !(last_req == RNG_REQ_NONE && rng_start == RNG_REQ_SPARSE)
			&& !(last_req == RNG_REQ_SPARSE && rng_start == RNG_REQ_NONE && done !== 1'b1))
		else begin
			$display("[ERROR] %0d ns: rng_start went from %b to %b (done=%b)",
				$time, last_req, rng_start, done);
			errors++;
		end
		last_req = rng_start;
	end

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		int run_no;
		int errors_before;
		run_no = 0;
		rst_b = 1'b0;
		start = 1'b0;
		rng_valid = 1'b0;
		rng_in = '0;
		rd_addr = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_b = 1'b1;
		@(negedge clk);
		errors_before = errors;
		assert (done === 1'b0 && rng_start === RNG_REQ_NONE) else begin
			$display("[ERROR] %0d ns: idle outputs done=%b rng_start=%b", $time, done, rng_start);
			errors++;
		end
		report_test("reset state", errors_before);
		for (int row = 0; row < N_ROWS; row++) begin
			for (int rep = 0; rep < row_runs[row]; rep++) begin
				errors_before = errors;
				cur_row = row;
				force_pos = 0;
				dense_q.delete();
				sparse_q.delete();
				start = 1'b1;
				@(negedge clk);
				start = 1'b0;
				while (done !== 1'b1)
					@(negedge clk);
				check_memories();
				report_test($sformatf("run %0d (row %0d)", run_no, row), errors_before);
				run_no++;
			end
		end
		$display("tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// watchdog scaled by the number of runs
	initial begin
		int total_runs;
		int limit;
		total_runs = 0;
		for (int i = 0; i < N_ROWS; i++)
			total_runs += row_runs[i];
		limit = total_runs * (G_WORDS + H_PAIRS) * 8 + 100;
		repeat (limit) @(posedge clk);
		$display("timeout: the runs did not finish within %0d clock periods", limit);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
src/keygen_pkg.sv
src/poly_mem_if.sv
src/keygen_fsm.sv
src/fill_counter.sv
src/rng_sampler.sv
src/sample_fifo.sv
src/poly_ram.sv
src/poly_loader.sv
src/keygen_top.sv
dv/keygen_checker.sv
dv/keygen_tb.sv
